// File: common/dot_pkg.sv
package dot_pkg;

    typedef logic [2:0] digit_t;
    typedef logic [2:0] row_idx_t;
    typedef logic [7:0] col_t;      // one bit per led, 1 = lit
    typedef logic [7:0] row_sel_t;  // active low
    typedef logic [3:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic   start;  // single cycle
        logic   stop;   // single cycle
        digit_t load_value;
    } timer_cmd_t;

    typedef struct packed {
        digit_t digit;
        logic   running;
        logic   done;
    } timer_stat_t;

    typedef struct packed {
        row_sel_t row;
        col_t     colr;
        col_t     colg;
    } matrix_drive_t;

    localparam apb_addr_t REG_CTRL   = 4'h0;
    localparam apb_addr_t REG_LOAD   = 4'h4;
    localparam apb_addr_t REG_STATUS = 4'h8;

endpackage

// File: dot_countdown_top.f
common/dot_pkg.sv
logic/apb_regs.sv
logic/countdown_timer.sv
dot_matrix/glyph_rom.sv
dot_matrix/dot_matrix_scan.sv
logic/dot_countdown_top.sv
tests/dot_countdown_tb.sv

// File: dot_matrix/dot_matrix_scan.sv
module dot_matrix_scan import dot_pkg::*; #(
    parameter int SCAN_DIV = 1
) (
    input  logic          clk,
    input  logic          rst,
    input  digit_t        digit,
    output matrix_drive_t drive
);

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    logic              scan_step;
    row_idx_t          row_idx;
    col_t              glyph_r;
    col_t              glyph_g;

    assign scan_step = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            row_idx  <= '0;
        end
        else if (scan_step)
        begin
            scan_cnt <= '0;
            row_idx  <= row_idx + row_idx_t'(1); // 7 wraps to 0
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    glyph_rom u_glyph (
        .digit   (digit),
        .row_idx (row_idx),
        .colr    (glyph_r),
        .colg    (glyph_g)
    );

    // row select and columns move on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            drive.row  <= '1; // all rows off
            drive.colr <= '0;
            drive.colg <= '0;
        end
        else
        begin
            drive.row  <= ~(row_sel_t'(1) << row_idx);
            drive.colr <= glyph_r;
            drive.colg <= glyph_g;
        end
    end

    // first edge out of reset loads the first row
    a_one_row_low: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(~drive.row)
    );

endmodule

// File: dot_matrix/glyph_rom.sv
module glyph_rom import dot_pkg::*; (
    input  digit_t   digit,
    input  row_idx_t row_idx,
    output col_t     colr,
    output col_t     colg
);

    col_t glyph;
    logic red_on;
    logic green_on;

    always_comb
    begin
        glyph = 8'b0000_0000; // row 0 and digits 6, 7 stay dark
        case (digit)
            3'd5:
                case (row_idx)
                    3'd1:       glyph = 8'b0111_1110;
                    3'd2:       glyph = 8'b0110_0000;
                    3'd3:       glyph = 8'b0111_1100;
                    3'd4, 3'd5: glyph = 8'b0000_0110;
                    3'd6:       glyph = 8'b0110_0110;
                    3'd7:       glyph = 8'b0011_1100;
                    default:    glyph = 8'b0000_0000;
                endcase
            3'd4:
                case (row_idx)
                    3'd1, 3'd6, 3'd7: glyph = 8'b0000_1100;
                    3'd2:             glyph = 8'b0001_1100;
                    3'd3:             glyph = 8'b0010_1100;
                    3'd4:             glyph = 8'b0100_1100;
                    3'd5:             glyph = 8'b0111_1110;
                    default:          glyph = 8'b0000_0000;
                endcase
            3'd3:
                case (row_idx)
                    3'd1, 3'd7: glyph = 8'b0011_1100;
                    3'd2, 3'd6: glyph = 8'b0110_0110;
                    3'd3, 3'd5: glyph = 8'b0000_0110;
                    3'd4:       glyph = 8'b0001_1100;
                    default:    glyph = 8'b0000_0000;
                endcase
            3'd2:
                case (row_idx)
                    3'd1:    glyph = 8'b0011_1100;
                    3'd2:    glyph = 8'b0110_0110;
                    3'd3:    glyph = 8'b0000_0110;
                    3'd4:    glyph = 8'b0000_1100;
                    3'd5:    glyph = 8'b0011_0000;
                    3'd6:    glyph = 8'b0110_0000;
                    3'd7:    glyph = 8'b0111_1110;
                    default: glyph = 8'b0000_0000;
                endcase
            3'd1:
                case (row_idx)
                    3'd3:    glyph = 8'b0011_1000;
                    3'd7:    glyph = 8'b0111_1110;
                    3'd0:    glyph = 8'b0000_0000;
                    default: glyph = 8'b0001_1000; // the stem
                endcase
            3'd0:
                case (row_idx)
                    3'd1, 3'd7: glyph = 8'b0011_1100;
                    3'd0:       glyph = 8'b0000_0000;
                    default:    glyph = 8'b0100_0010;
                endcase
            default:
                glyph = 8'b0000_0000;
        endcase
    end

    // 5,4 red; 3,2 yellow; 1,0 green
    assign red_on   = (digit >= 3'd2) && (digit <= 3'd5);
    assign green_on = (digit <= 3'd3);

    assign colr = red_on   ? glyph : '0;
    assign colg = green_on ? glyph : '0;

endmodule

// File: logic/apb_regs.sv
module apb_regs import dot_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output timer_cmd_t  cmd,
    input  timer_stat_t stat
);

    logic   access;
    logic   wr_access;
    logic   rd_access;
    logic   addr_ok;
    logic   wr_ctrl;
    logic   wr_load;
    digit_t load_q;

    // second phase of a transfer, always completes
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    always_comb
    begin
        case (apb_req.paddr)
            REG_CTRL, REG_LOAD, REG_STATUS: addr_ok = 1'b1;
            default:                        addr_ok = 1'b0;
        endcase
    end

    assign wr_ctrl = wr_access && (apb_req.paddr == REG_CTRL);
    assign wr_load = wr_access && (apb_req.paddr == REG_LOAD);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            load_q <= digit_t'(5);
        else if (wr_load)
            load_q <= apb_req.pwdata[2:0];
    end

    // stop has priority over start
    assign cmd.stop       = wr_ctrl && apb_req.pwdata[1];
    assign cmd.start      = wr_ctrl && apb_req.pwdata[0] && !apb_req.pwdata[1];
    assign cmd.load_value = load_q;

    always_comb
    begin
        apb_rsp.prdata = '0;
        if (rd_access)
        begin
            case (apb_req.paddr)
                REG_LOAD:
                    apb_rsp.prdata[2:0] = load_q;
                REG_STATUS:
                begin
                    apb_rsp.prdata[2:0] = stat.digit;
                    apb_rsp.prdata[4]   = stat.running;
                    apb_rsp.prdata[5]   = stat.done;
                end
                default:
                    apb_rsp.prdata = '0; // ctrl reads as zero
            endcase
        end
    end

    assign apb_rsp.pready = 1'b1;

    // bad address, or write to the read-only status word
    assign apb_rsp.pslverr = access &&
                             (!addr_ok || (apb_req.pwrite && apb_req.paddr == REG_STATUS));

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel
    );

endmodule

// File: logic/countdown_timer.sv
module countdown_timer import dot_pkg::*; #(
    parameter int TICK_DIV = 1000
) (
    input  logic        clk,
    input  logic        rst,
    input  timer_cmd_t  cmd,
    output timer_stat_t stat
);

    localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_t;

    state_t            state;
    logic [TICK_W-1:0] tick_cnt;
    digit_t            digit_q;
    logic              tick_end;

    assign tick_end = (tick_cnt == TICK_W'(TICK_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            digit_q  <= '0;
        end
        else if (cmd.stop)
        begin
            // digit and done stay as they are
            if (state == ST_RUN)
                state <= ST_IDLE;
        end
        else if (cmd.start)
        begin
            digit_q  <= cmd.load_value;
            tick_cnt <= '0;
            if (cmd.load_value == '0)
                state <= ST_DONE; // nothing to count
            else
                state <= ST_RUN;
        end
        else if (state == ST_RUN)
        begin
            if (tick_end)
            begin
                tick_cnt <= '0;
                digit_q  <= digit_q - digit_t'(1);
                if (digit_q == digit_t'(1))
                    state <= ST_DONE;
            end
            else
            begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign stat.digit   = digit_q;
    assign stat.running = (state == ST_RUN);
    assign stat.done    = (state == ST_DONE);

    // only a (re)start may move the digit upwards
    a_no_count_up: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_RUN && !cmd.start) |=> (digit_q <= $past(digit_q))
    );

endmodule

// File: logic/dot_countdown_top.sv
module dot_countdown_top import dot_pkg::*; #(
    parameter int TICK_DIV = 1000,
    parameter int SCAN_DIV = 1
) (
    input  logic          clk,
    input  logic          rst,
    input  apb_req_t      apb_req,
    output apb_rsp_t      apb_rsp,
    output matrix_drive_t drive
);

    timer_cmd_t  cmd;
    timer_stat_t stat;

    apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cmd     (cmd),
        .stat    (stat)
    );

    countdown_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_timer (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .stat (stat)
    );

    dot_matrix_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scan (
        .clk   (clk),
        .rst   (rst),
        .digit (stat.digit), // shown digit straight from the timer
        .drive (drive)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module dot_countdown_tb \
    -f dot_countdown_top.f -o dot_countdown_sim

out=$(./obj_dir/dot_countdown_sim)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: tests/dot_countdown_tb.sv
module dot_countdown_tb import dot_pkg::*;;

    localparam int TICK = 40;
    localparam int MAX_CYCLES = 8000;

    logic          clk;
    logic          rst;
    apb_req_t      apb_req;
    apb_rsp_t      apb_rsp;
    matrix_drive_t drive;

    int        errors = 0;
    int        cycles = 0;
    logic [31:0] lcg_state;

    // reference model of the counter and scanner
    digit_t    m_load;
    digit_t    m_digit;
    logic      m_running;
    logic      m_done;
    int        m_tick;
    row_idx_t  m_row;
    digit_t    shown_digit; // what the matrix drive reflects this cycle
    row_idx_t  shown_row;
    logic      scan_live;

    logic      bus_access;
    logic      ctrl_start;
    logic      ctrl_stop;
    logic      exp_err;
    apb_data_t exp_rdata;

    dot_countdown_top #(
        .TICK_DIV (TICK),
        .SCAN_DIV (1)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .drive   (drive)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // bitmap bytes from row 7 down to row 0
    function automatic col_t glyph_bits(input digit_t d, input row_idx_t r);
        logic [63:0] bitmap;
        case (d)
            3'd5:    bitmap = 64'h3C66_0606_7C60_7E00;
            3'd4:    bitmap = 64'h0C0C_7E4C_2C1C_0C00;
            3'd3:    bitmap = 64'h3C66_061C_0666_3C00;
            3'd2:    bitmap = 64'h7E60_300C_0666_3C00;
            3'd1:    bitmap = 64'h7E18_1818_3818_1800;
            3'd0:    bitmap = 64'h3C42_4242_4242_3C00;
            default: bitmap = 64'h0;
        endcase
        return bitmap[int'(r) * 8 +: 8];
    endfunction

    function automatic col_t expected_red(input digit_t d, input row_idx_t r);
        case (d)
            3'd5, 3'd4, 3'd3, 3'd2: return glyph_bits(d, r);
            default:                return '0;
        endcase
    endfunction

    function automatic col_t expected_green(input digit_t d, input row_idx_t r);
        case (d)
            3'd3, 3'd2, 3'd1, 3'd0: return glyph_bits(d, r);
            default:                return '0;
        endcase
    endfunction

    assign bus_access = apb_req.psel && apb_req.penable;
    assign ctrl_stop  = bus_access && apb_req.pwrite && apb_req.paddr == REG_CTRL
                        && apb_req.pwdata[1];
    assign ctrl_start = bus_access && apb_req.pwrite && apb_req.paddr == REG_CTRL
                        && apb_req.pwdata[0] && !apb_req.pwdata[1];
    assign exp_err    = bus_access && ((apb_req.paddr != REG_CTRL && apb_req.paddr != REG_LOAD
                        && apb_req.paddr != REG_STATUS)
                        || (apb_req.pwrite && apb_req.paddr == REG_STATUS));

    always_comb
    begin
        exp_rdata = '0;
        if (apb_req.paddr == REG_LOAD)
            exp_rdata[2:0] = m_load;
        else if (apb_req.paddr == REG_STATUS)
        begin
            exp_rdata[2:0] = m_digit;
            exp_rdata[4]   = m_running;
            exp_rdata[5]   = m_done;
        end
    end

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_load      <= 3'd5;
            m_digit     <= '0;
            m_running   <= 1'b0;
            m_done      <= 1'b0;
            m_tick      <= 0;
            m_row       <= '0;
            shown_digit <= '0;
            shown_row   <= '0;
            scan_live   <= 1'b0;
        end
        else
        begin
            assert (apb_rsp.pready && apb_rsp.pslverr == exp_err) else
            begin
                errors = errors + 1;
                $display("** Error [%0t] addr %h pslverr %b pready %b, expected pslverr %b",
                         $time, apb_req.paddr, apb_rsp.pslverr, apb_rsp.pready, exp_err);
            end
            if (bus_access && !apb_req.pwrite)
                assert (apb_rsp.prdata == exp_rdata) else
                begin
                    errors = errors + 1;
                    $display("** Error [%0t] read addr %h got %h expected %h",
                             $time, apb_req.paddr, apb_rsp.prdata, exp_rdata);
                end
            if (scan_live)
            begin
                assert (drive.row == ~(8'b1 << shown_row)) else
                begin
                    errors = errors + 1;
                    $display("** Error [%0t] row %b expected row %0d low",
                             $time, drive.row, shown_row);
                end
                assert (drive.colr == expected_red(shown_digit, shown_row) &&
                        drive.colg == expected_green(shown_digit, shown_row)) else
                begin
                    errors = errors + 1;
                    $display("** Error [%0t] digit %0d row %b cols r %h g %h wrong",
                             $time, shown_digit, drive.row, drive.colr, drive.colg);
                end
            end
            else
                assert (drive.row == 8'hFF && drive.colr == '0 && drive.colg == '0) else
                begin
                    errors = errors + 1;
                    $display("** Error [%0t] matrix not dark after reset", $time);
                end

            if (bus_access && apb_req.pwrite && apb_req.paddr == REG_LOAD)
                m_load <= apb_req.pwdata[2:0];
            if (ctrl_stop)
                m_running <= 1'b0;
            else if (ctrl_start)
            begin
                m_digit   <= m_load;
                m_tick    <= 0;
                m_running <= (m_load != 3'd0);
                m_done    <= (m_load == 3'd0);
            end
            else if (m_running)
            begin
                if (m_tick == TICK - 1)
                begin
                    m_tick  <= 0;
                    m_digit <= m_digit - 3'd1;
                    if (m_digit == 3'd1)
                    begin
                        m_running <= 1'b0;
                        m_done    <= 1'b1;
                    end
                end
                else
                    m_tick <= m_tick + 1;
            end
            m_row       <= m_row + 3'd1;
            shown_row   <= m_row;
            shown_digit <= m_digit;
            scan_live   <= 1'b1;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b1;
        apb_req.pwdata  = data;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // poll the status word until done is up
    task automatic wait_done();
        apb_data_t rdata;
        logic      err;
        rdata = '0;
        while (!rdata[5])
            apb_read(REG_STATUS, rdata, err);
    endtask

    initial
    begin
        apb_data_t rdata;
        logic      err;
        rst       = 1'b1;
        apb_req   = '0;
        lcg_state = 32'ha7b4ac43;
        idle(5);
        rst = 1'b0;
        idle(3);
        apb_read(REG_STATUS, rdata, err);
        apb_read(REG_LOAD, rdata, err);
        apb_read(REG_CTRL, rdata, err);
        idle(10);

        apb_write(REG_CTRL, 32'h1); // count down from the reset value
        wait_done();
        idle(5);

        for (int i = 0; i < 8; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            apb_write(REG_LOAD, {29'b0, lcg_state[18:16]});
            apb_write(REG_CTRL, 32'h1);
            wait_done();
            idle(5);
        end

        apb_write(REG_LOAD, 32'h5);
        apb_write(REG_CTRL, 32'h1);
        idle(90);
        apb_write(REG_CTRL, 32'h3);    // both bits, stop wins
        idle(130);
        apb_read(REG_STATUS, rdata, err);
        apb_write(REG_CTRL, 32'h1);
        idle(50);
        apb_write(REG_CTRL, 32'h1);    // restart while running
        wait_done();

        apb_write(REG_STATUS, 32'h7);
        apb_write(4'hC, 32'h2);
        apb_read(4'hC, rdata, err);
        apb_read(REG_LOAD, rdata, err);
        apb_read(REG_STATUS, rdata, err);

        apb_write(REG_LOAD, 32'h0);
        apb_write(REG_CTRL, 32'h1);
        apb_read(REG_STATUS, rdata, err);
        idle(20);

        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
